// ==== design/spi_host_pkg.sv ====
/*
 * Shared widths, command layout and sequencer state encoding for the SPI host.
 * Every block refers to these through scoped names.
 * Delays and half periods are stored as value minus one, the byte count as bytes minus one.
 */
`default_nettype none

package spi_host_pkg;

  // Half period is clkdiv + 1 system clocks
  localparam int CLKDIV_W = 16;
  // Lead, trail and idle each last value + 1 half periods
  localparam int DELAY_W  = 4;
  // Byte count minus one
  localparam int LEN_W    = 8;
  localparam int BYTE_W   = 8;
  // Bit index inside one byte
  localparam int BIT_W    = $clog2(BYTE_W);

  // One segment command as presented by the host
  typedef struct packed {
    logic                cpol;
    logic                cpha;
    logic [CLKDIV_W-1:0] clkdiv;
    logic [DELAY_W-1:0]  csnlead;
    logic [DELAY_W-1:0]  csntrail;
    logic [DELAY_W-1:0]  csnidle;
    logic [LEN_W-1:0]    len;
    // Keep chip select low after the last byte
    logic                csaat;
  } cmd_t;

  // Chip-select sequencer states
  typedef enum logic [2:0] {
    Idle,
    WaitLead,
    ClkLow,
    ClkHigh,
    WaitTrail,
    WaitIdle,
    // Extra idle gap before a new configuration takes over
    CfgSwitch,
    // Segment done, chip select still held low
    IdleCsActive
  } seq_state_e;

endpackage

`default_nettype wire

// ==== design/spi_bit_if.sv ====
/*
 * Per-bit timing events from the chip-select sequencer to the shift/IO block.
 * Strobes last one system clock; sck_d and cs_active_d are the levels
 * the output flops take on the next edge.
 */
`default_nettype none

interface spi_bit_if;

  // Load next transmit byte, also the pop strobe to the host
  logic byte_start;
  // Shift out the next bit
  logic bit_launch;
  // Capture the input line
  logic bit_sample;
  // Eighth sample of a byte
  logic byte_end;
  // Next serial clock and chip-select levels
  logic sck_d;
  logic cs_active_d;
  // Idle clock level of the current segment
  logic cpol;

  modport seq (
    output byte_start, bit_launch, bit_sample, byte_end, sck_d, cs_active_d, cpol
  );

  modport shf (
    input byte_start, bit_launch, bit_sample, byte_end, sck_d, cs_active_d, cpol
  );

endinterface

`default_nettype wire

// ==== design/spi_cmd_latch.sv ====
/*
 * Command input stage of the SPI host.
 * Takes a single-cycle command strobe while the sequencer is ready, holds the
 * active command and flags whether its clock or delay settings differ from the last one.
 */
`default_nettype none

module spi_cmd_latch (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               cmd_valid_i,
  input  spi_host_pkg::cmd_t cmd_i,
  input  logic               ready_i,
  output spi_host_pkg::cmd_t cmd_q_o,
  output logic               cmd_new_o,
  output logic               cfg_changed_o
);

  logic accept;
  logic cfg_diff;

  // Strobes outside a ready cycle are dropped
  assign accept = cmd_valid_i & ready_i;

  // Segment fields (len, csaat) may change freely between held segments
  assign cfg_diff = (cmd_i.cpol     != cmd_q_o.cpol)     ||
                    (cmd_i.cpha     != cmd_q_o.cpha)     ||
                    (cmd_i.clkdiv   != cmd_q_o.clkdiv)   ||
                    (cmd_i.csnlead  != cmd_q_o.csnlead)  ||
                    (cmd_i.csntrail != cmd_q_o.csntrail) ||
                    (cmd_i.csnidle  != cmd_q_o.csnidle);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmd_q_o       <= '0;
      cmd_new_o     <= 1'b0;
      cfg_changed_o <= 1'b0;
    end else begin
      // New command visible together with the strobe
      cmd_new_o     <= accept;
      cfg_changed_o <= accept & cfg_diff;
      if (accept) begin
        cmd_q_o <= cmd_i;
      end
    end
  end

  // Ready must drop right after an acceptance
  NoBackToBackCmd_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmd_new_o |=> !cmd_new_o
  ) else $error("command accepted in two consecutive cycles");

endmodule

`default_nettype wire

// ==== design/spi_seq_fsm.sv ====
/*
 * Chip-select sequencer of the SPI host.
 * Paces the segment with a half-period divider and a delay counter, counts bits
 * and bytes, and emits the launch, sample and byte events for both clock phases.
 */
`default_nettype none

module spi_seq_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  spi_host_pkg::cmd_t cmd_q_i,
  input  logic               cmd_new_i,
  input  logic               cfg_changed_i,
  input  logic               cmd_valid_i,
  output logic               ready_o,
  spi_bit_if.seq             bus
);

  spi_host_pkg::seq_state_e          state_q, state_d;
  spi_host_pkg::seq_state_e          end_state, clk_first;
  logic [spi_host_pkg::CLKDIV_W-1:0] div_q, div_d;
  logic [spi_host_pkg::DELAY_W-1:0]  wait_q, wait_d;
  logic [spi_host_pkg::BIT_W-1:0]    bit_q;
  logic [spi_host_pkg::LEN_W-1:0]    byte_q;
  logic ready_q, cfg_pend_q, cpol_act_q, cpol_use;
  logic cpha, is_idle, cs_high_q, fsm_en, last_bit, last_byte;
  logic changing, to_low, to_high, start0, start1, launch0, launch1, byte_next;

  assign cpha      = cmd_q_i.cpha;
  assign is_idle   = (state_q == spi_host_pkg::Idle) || (state_q == spi_host_pkg::IdleCsActive);
  assign cs_high_q = (state_q == spi_host_pkg::Idle) || (state_q == spi_host_pkg::WaitIdle) ||
                     (state_q == spi_host_pkg::CfgSwitch);
  // Idle states react at once, all others step on divider terminal count
  assign fsm_en    = is_idle || (div_q == '0);
  assign last_bit  = (bit_q == '0);
  assign last_byte = (byte_q == '0);
  assign end_state = cmd_q_i.csaat ? spi_host_pkg::IdleCsActive : spi_host_pkg::WaitTrail;
  assign clk_first = cpha ? spi_host_pkg::ClkHigh : spi_host_pkg::ClkLow;

  // Divider restarts on every new command so the first half period is full
  always_comb begin
    if (cmd_new_i) div_d = cmd_q_i.clkdiv;
    else if (is_idle) div_d = div_q;
    else if (div_q == '0) div_d = cmd_q_i.clkdiv;
    else div_d = div_q - 1'b1;
  end

  always_comb begin
    state_d = state_q;
    if (fsm_en) begin
      case (state_q)
        spi_host_pkg::Idle: begin
          if (cmd_new_i) begin
            state_d = cfg_changed_i ? spi_host_pkg::CfgSwitch : spi_host_pkg::WaitLead;
          end
        end
        spi_host_pkg::WaitLead: begin
          if (wait_q == '0) state_d = spi_host_pkg::ClkHigh;
        end
        // Phase 1 segments end in ClkLow, phase 0 in ClkHigh
        spi_host_pkg::ClkLow: begin
          if (!last_bit || !last_byte || !cpha) state_d = spi_host_pkg::ClkHigh;
          else state_d = end_state;
        end
        spi_host_pkg::ClkHigh: begin
          if (!last_bit || !last_byte || cpha) state_d = spi_host_pkg::ClkLow;
          else state_d = end_state;
        end
        spi_host_pkg::WaitTrail: begin
          if (wait_q == '0) state_d = spi_host_pkg::WaitIdle;
        end
        spi_host_pkg::WaitIdle: begin
          if (wait_q == '0) begin
            state_d = cfg_pend_q ? spi_host_pkg::CfgSwitch : spi_host_pkg::Idle;
          end
        end
        spi_host_pkg::CfgSwitch: begin
          if (wait_q == '0) state_d = spi_host_pkg::WaitLead;
        end
        spi_host_pkg::IdleCsActive: begin
          // Same configuration continues without lead, otherwise close and reopen
          if (cmd_new_i) state_d = cfg_changed_i ? spi_host_pkg::WaitTrail : clk_first;
        end
        default: state_d = spi_host_pkg::Idle;
      endcase
    end
  end

  assign changing = (state_d != state_q);

  // Delay counter loads on state entry, counts half periods
  always_comb begin
    wait_d = wait_q;
    if (changing) begin
      case (state_d)
        spi_host_pkg::WaitLead:  wait_d = cmd_q_i.csnlead;
        spi_host_pkg::WaitTrail: wait_d = cmd_q_i.csntrail;
        spi_host_pkg::WaitIdle,
        spi_host_pkg::CfgSwitch: wait_d = cmd_q_i.csnidle;
        default:                 wait_d = '0;
      endcase
    end else if (fsm_en && (wait_q != '0)) begin
      wait_d = wait_q - 1'b1;
    end
  end

  // Bit events from clock state changes
  assign to_low  = changing && (state_d == spi_host_pkg::ClkLow);
  assign to_high = changing && (state_d == spi_host_pkg::ClkHigh);
  // Phase 0 puts the first bit out with chip select, before any edge
  assign start0  = (changing && (state_d == spi_host_pkg::WaitLead)) || (to_low && last_bit);
  assign launch0 = to_low && !last_bit;
  assign start1  = to_high && last_bit;
  assign launch1 = to_high && !last_bit;

  assign bus.byte_start = cpha ? start1 : start0;
  assign bus.bit_launch = cpha ? launch1 : launch0;
  assign bus.bit_sample = cpha ? to_low : to_high;
  assign bus.byte_end   = bus.bit_sample && last_bit;

  // Only bytes after the first in a segment consume the count
  assign byte_next = bus.byte_start &&
                     ((state_q == spi_host_pkg::ClkLow) || (state_q == spi_host_pkg::ClkHigh));

  // Held chip select keeps the old idle level until it rises
  assign cpol_use        = cs_high_q ? cmd_q_i.cpol : cpol_act_q;
  assign bus.cpol        = cpol_use;
  assign bus.sck_d       = cpol_use ^ (state_d == spi_host_pkg::ClkHigh);
  assign bus.cs_active_d = (state_d == spi_host_pkg::WaitLead)  ||
                           (state_d == spi_host_pkg::ClkLow)    ||
                           (state_d == spi_host_pkg::ClkHigh)   ||
                           (state_d == spi_host_pkg::WaitTrail) ||
                           (state_d == spi_host_pkg::IdleCsActive);
  assign ready_o = ready_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= spi_host_pkg::Idle;
      div_q      <= '0;
      wait_q     <= '0;
      bit_q      <= '0;
      byte_q     <= '0;
      ready_q    <= 1'b1;
      cfg_pend_q <= 1'b0;
      cpol_act_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      div_q      <= div_d;
      wait_q     <= wait_d;
      cpol_act_q <= cpol_use;
      // Ready drops after an accepted strobe, returns in an idle state
      ready_q    <= !(cmd_valid_i && ready_q) &&
                    ((state_d == spi_host_pkg::Idle) || (state_d == spi_host_pkg::IdleCsActive));
      // Start at the MSB index
      if (bus.byte_start) bit_q <= '1;
      else if (bus.bit_launch) bit_q <= bit_q - 1'b1;
      if (cmd_new_i) byte_q <= cmd_q_i.len;
      else if (byte_next) byte_q <= byte_q - 1'b1;
      // Remember a held segment that closes for a configuration change
      if ((state_q == spi_host_pkg::IdleCsActive) && (state_d == spi_host_pkg::WaitTrail)) begin
        cfg_pend_q <= 1'b1;
      end else if ((state_q == spi_host_pkg::WaitIdle) && changing) begin
        cfg_pend_q <= 1'b0;
      end
    end
  end

  ReadyLowWhileClocking_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    ((state_q == spi_host_pkg::ClkLow) || (state_q == spi_host_pkg::ClkHigh)) |-> !ready_o
  ) else $error("ready high during serial clocking");

endmodule

`default_nettype wire

// ==== design/spi_shift_io.sv ====
/*
 * Output side of the SPI host.
 * Registers the serial clock and chip select, shifts transmit bytes out MSB first
 * and collects received bits into bytes, all paced by the sequencer's bit events.
 */
`default_nettype none

module spi_shift_io (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  spi_bit_if.shf                          bus,
  input  logic [spi_host_pkg::BYTE_W-1:0] tx_byte_i,
  input  logic                            sd_i,
  output logic                            tx_pop_o,
  output logic [spi_host_pkg::BYTE_W-1:0] rx_byte_o,
  output logic                            rx_valid_o,
  output logic                            sck_o,
  output logic                            csb_o,
  output logic                            sd_o,
  output logic                            sd_en_o
);

  logic [spi_host_pkg::BYTE_W-1:0] tx_q;
  logic [spi_host_pkg::BYTE_W-1:0] rx_q;

  // Host byte is taken in the pop cycle itself
  assign tx_pop_o = bus.byte_start;
  assign sd_o     = tx_q[spi_host_pkg::BYTE_W-1];
  // Single data lane, driven for the whole chip-select window
  assign sd_en_o  = ~csb_o;

  // Clock and chip select change on the same edge as the sequencer state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sck_o      <= 1'b0;
      csb_o      <= 1'b1;
      rx_valid_o <= 1'b0;
    end else begin
      sck_o      <= bus.sck_d;
      csb_o      <= ~bus.cs_active_d;
      // One cycle after the eighth sample
      rx_valid_o <= bus.byte_end;
    end
  end

  always_ff @(posedge clk_i) begin
    if (bus.byte_start) begin
      tx_q <= tx_byte_i;
    end else if (bus.bit_launch) begin
      tx_q <= {tx_q[spi_host_pkg::BYTE_W-2:0], 1'b0};
    end
    if (bus.bit_sample) begin
      rx_q <= {rx_q[spi_host_pkg::BYTE_W-2:0], sd_i};
    end
    // Last bit goes straight into the published byte
    if (bus.byte_end) begin
      rx_byte_o <= {rx_q[spi_host_pkg::BYTE_W-2:0], sd_i};
    end
  end

  // Serial clock parks at the segment polarity whenever the device is deselected
  // Polarity needs one cycle to reach the clock flop after it changes
  SckIdleLevel_A: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (csb_o && $stable(bus.cpol)) |-> (sck_o == bus.cpol)
  ) else $error("serial clock not at idle level with chip select high");

endmodule

`default_nettype wire

// ==== design/spi_host.sv ====
/*
 * SPI host sequencer top level, single chip select, standard mode.
 * Connect a host command port, a transmit byte source that answers tx_pop_o
 * and a receive sink for rx_valid_o; SPI pins go straight to the device.
 */
`default_nettype none

module spi_host (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            cmd_valid_i,
  input  spi_host_pkg::cmd_t              cmd_i,
  output logic                            ready_o,
  input  logic [spi_host_pkg::BYTE_W-1:0] tx_byte_i,
  output logic                            tx_pop_o,
  output logic [spi_host_pkg::BYTE_W-1:0] rx_byte_o,
  output logic                            rx_valid_o,
  input  logic                            sd_i,
  output logic                            sck_o,
  output logic                            csb_o,
  output logic                            sd_o,
  output logic                            sd_en_o
);

  spi_host_pkg::cmd_t cmd_q;
  logic               cmd_new;
  logic               cfg_changed;

  // Bit events between sequencer and shifter
  spi_bit_if bit_bus ();

  spi_cmd_latch u_cmd_latch (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_i         (cmd_i),
    .ready_i       (ready_o),
    .cmd_q_o       (cmd_q),
    .cmd_new_o     (cmd_new),
    .cfg_changed_o (cfg_changed)
  );

  spi_seq_fsm u_seq_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_q_i       (cmd_q),
    .cmd_new_i     (cmd_new),
    .cfg_changed_i (cfg_changed),
    .cmd_valid_i   (cmd_valid_i),
    .ready_o       (ready_o),
    .bus           (bit_bus.seq)
  );

  spi_shift_io u_shift_io (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .bus        (bit_bus.shf),
    .tx_byte_i  (tx_byte_i),
    .sd_i       (sd_i),
    .tx_pop_o   (tx_pop_o),
    .rx_byte_o  (rx_byte_o),
    .rx_valid_o (rx_valid_o),
    .sck_o      (sck_o),
    .csb_o      (csb_o),
    .sd_o       (sd_o),
    .sd_en_o    (sd_en_o)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_spi_host.sv ====
/*
 * Testbench for the SPI host sequencer with sd_o looped back to sd_i.
 * Runs a table of segment commands and checks loopback data, clock idle level,
 * edge counts, half periods, chip-select holding and strobes given while busy.
 */
`default_nettype none

module tb_spi_host;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_SEGS   = 9;
  localparam int RAND_SEED  = 32'hb9a4ee73;

  typedef logic [spi_host_pkg::BYTE_W-1:0] byte_t;

  logic               clk_i;
  logic               rst_ni;
  logic               cmd_valid_i;
  spi_host_pkg::cmd_t cmd_i;
  logic               ready_o;
  byte_t              tx_byte_i;
  logic               tx_pop_o;
  byte_t              rx_byte_o;
  logic               rx_valid_o;
  logic               sck_o;
  logic               csb_o;
  logic               sd_o;
  logic               sd_en_o;

  spi_host_pkg::cmd_t seg_tab [NUM_SEGS];
  // Stimulus bytes in pop order, and bytes popped but not yet received
  byte_t tx_data [$];
  byte_t exp_q [$];
  int    tx_idx;
  int    run_len;
  int    cur_half;
  int    pop_cnt;
  int    rx_cnt;
  int    edge_cnt;
  int    fall_cnt;
  logic  prev_sck;
  logic  prev_csb;
  logic  have_ref;
  logic  last_cpol;

  spi_host dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .ready_o     (ready_o),
    .tx_byte_i   (tx_byte_i),
    .tx_pop_o    (tx_pop_o),
    .rx_byte_o   (rx_byte_o),
    .rx_valid_o  (rx_valid_o),
    .sd_i        (sd_o),
    .sck_o       (sck_o),
    .csb_o       (csb_o),
    .sd_o        (sd_o),
    .sd_en_o     (sd_en_o)
  );

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_byte(input string sig, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch at %0t ns: %s = %h, expected %h", $time, sig, got, exp));
    end
  endtask

  task automatic check_level(input string sig, input logic got, input logic exp);
    if (got !== exp) begin
      report_error($sformatf("mismatch at %0t ns: %s = %b, expected %b", $time, sig, got, exp));
    end
  endtask

  task automatic check_count(input string sig, input int got, input int exp);
    if (got != exp) begin
      report_error($sformatf("mismatch at %0t ns: %s = %0d, expected %0d", $time, sig, got, exp));
    end
  endtask

  function automatic spi_host_pkg::cmd_t make_cmd(input logic cpol, input logic cpha,
                                                  input int clkdiv, input int lead,
                                                  input int trail, input int idle,
                                                  input int nbytes, input logic hold);
    spi_host_pkg::cmd_t c;
    int len;
    len        = nbytes - 1;
    c.cpol     = cpol;
    c.cpha     = cpha;
    c.clkdiv   = clkdiv[spi_host_pkg::CLKDIV_W-1:0];
    c.csnlead  = lead[spi_host_pkg::DELAY_W-1:0];
    c.csntrail = trail[spi_host_pkg::DELAY_W-1:0];
    c.csnidle  = idle[spi_host_pkg::DELAY_W-1:0];
    c.len      = len[spi_host_pkg::LEN_W-1:0];
    c.csaat    = hold;
    return c;
  endfunction

  // Clock and delay settings only, byte count and hold flag excluded
  function automatic logic same_config(input spi_host_pkg::cmd_t a, input spi_host_pkg::cmd_t b);
    return (a.cpol == b.cpol) && (a.cpha == b.cpha) && (a.clkdiv == b.clkdiv) &&
           (a.csnlead == b.csnlead) && (a.csntrail == b.csntrail) && (a.csnidle == b.csnidle);
  endfunction

  // Worst case per segment: all bits, four delays of 16 half periods, handshake slack
  function automatic longint run_budget();
    longint cycles;
    cycles = 200;
    foreach (seg_tab[i]) begin
      cycles += (16 * (int'(seg_tab[i].len) + 1) + 64) * (int'(seg_tab[i].clkdiv) + 1) + 20;
    end
    return cycles;
  endfunction

  task automatic run_segment(input int idx, input logic reopen);
    spi_host_pkg::cmd_t cmd;
    int nbytes;
    int pops0;
    int rx0;
    int edges0;
    int falls0;
    cmd    = seg_tab[idx];
    nbytes = int'(cmd.len) + 1;
    do @(posedge clk_i); while (ready_o !== 1'b1);
    cmd_i       <= cmd;
    cmd_valid_i <= 1'b1;
    @(posedge clk_i);
    // Ready holds until a strobe is taken, so this edge accepts
    check_level("ready_o", ready_o, 1'b1);
    pops0  = pop_cnt;
    rx0    = rx_cnt;
    edges0 = edge_cnt;
    falls0 = fall_cnt;
    // Second strobe with junk while busy, must be dropped
    cmd_i <= '1;
    @(posedge clk_i);
    check_level("ready_o", ready_o, 1'b0);
    cmd_valid_i <= 1'b0;
    do @(posedge clk_i); while (ready_o !== 1'b1);
    // One more edge lets the monitor count the last clock edge
    @(posedge clk_i);
    check_count("tx_pop_o count", pop_cnt - pops0, nbytes);
    check_count("rx_valid_o count", rx_cnt - rx0, nbytes);
    check_count("sck_o edge count", edge_cnt - edges0, 16 * nbytes);
    check_count("csb_o fall count", fall_cnt - falls0, reopen ? 1 : 0);
    // Held segment ends with the device still selected
    check_level("csb_o", csb_o, ~cmd.csaat);
  endtask

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Monitor samples the values from before each rising edge
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      prev_sck  = sck_o;
      prev_csb  = csb_o;
      have_ref  = 1'b0;
      run_len   = 0;
      tx_idx    = 0;
      tx_byte_i <= tx_data[0];
    end else begin
      // Parked clock while deselected and waiting for a command
      if (csb_o && ready_o) check_level("sck_o", sck_o, last_cpol);
      // Data line driven exactly while the device is selected
      check_level("sd_en_o", sd_en_o, csb_o === 1'b0);
      // Byte taken in the pop cycle, next one shown right after
      if (tx_pop_o) begin
        exp_q.push_back(tx_byte_i);
        tx_idx = tx_idx + 1;
        tx_byte_i <= (tx_idx < tx_data.size()) ? tx_data[tx_idx] : '0;
        pop_cnt <= pop_cnt + 1;
      end
      if (rx_valid_o) begin
        if (exp_q.size() == 0) begin
          report_error("receive strobe came with no transmit byte popped before it");
        end else begin
          check_byte("rx_byte_o", rx_byte_o, exp_q.pop_front());
          rx_cnt <= rx_cnt + 1;
        end
      end
      run_len = run_len + 1;
      if (csb_o) begin
        have_ref = 1'b0;
      end else if (sck_o !== prev_sck) begin
        edge_cnt <= edge_cnt + 1;
        if (have_ref) check_count("sck_o half period", run_len, cur_half);
        have_ref = 1'b1;
        run_len  = 0;
      end
      if (!csb_o && prev_csb) fall_cnt <= fall_cnt + 1;
      // New segment, gap since the last edge is not a half period
      if (cmd_valid_i && ready_o) begin
        last_cpol = cmd_i.cpol;
        cur_half  = int'(cmd_i.clkdiv) + 1;
        have_ref  = 1'b0;
      end
      prev_sck = sck_o;
      prev_csb = csb_o;
    end
  end

  initial begin
    @(posedge rst_ni);
    #(run_budget() * CLK_PERIOD);
    report_error("timeout, the command table did not finish in time");
  end

  initial begin
    int   seed_val;
    int   total;
    logic reopen;
    rst_ni      = 1'b0;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    tx_byte_i   = '0;
    last_cpol   = 1'b0;
    cur_half    = 1;
    pop_cnt     = 0;
    rx_cnt      = 0;
    edge_cnt    = 0;
    fall_cnt    = 0;
    seed_val    = $urandom(RAND_SEED);
    // cpol, cpha, clkdiv, lead, trail, idle, bytes, hold
    seg_tab[0] = make_cmd(1'b0, 1'b0, 1, 2, 1, 1, 3, 1'b0);
    seg_tab[1] = make_cmd(1'b0, 1'b1, 0, 0, 0, 0, 2, 1'b0);
    seg_tab[2] = make_cmd(1'b1, 1'b0, 2, 1, 2, 0, 2, 1'b0);
    seg_tab[3] = make_cmd(1'b1, 1'b1, 1, 3, 1, 2, 3, 1'b0);
    // Held chain with one configuration
    seg_tab[4] = make_cmd(1'b0, 1'b0, 0, 1, 1, 1, 2, 1'b1);
    seg_tab[5] = make_cmd(1'b0, 1'b0, 0, 1, 1, 1, 1, 1'b1);
    seg_tab[6] = make_cmd(1'b0, 1'b0, 0, 1, 1, 1, 3, 1'b0);
    // Held, then polarity change forces close and reopen
    seg_tab[7] = make_cmd(1'b1, 1'b1, 3, 0, 1, 0, 1, 1'b1);
    seg_tab[8] = make_cmd(1'b0, 1'b1, 3, 0, 1, 0, 2, 1'b0);
    total = 0;
    foreach (seg_tab[i]) total += int'(seg_tab[i].len) + 1;
    repeat (total) tx_data.push_back(byte_t'($urandom()));
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    for (int i = 0; i < NUM_SEGS; i++) begin
      if (i == 0) reopen = 1'b1;
      else reopen = !seg_tab[i-1].csaat || !same_config(seg_tab[i-1], seg_tab[i]);
      run_segment(i, reopen);
    end
    repeat (4) @(posedge clk_i);
    check_count("bytes popped but not received", exp_q.size(), 0);
    check_count("total tx_pop_o count", pop_cnt, total);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== spi_host.f ====
design/spi_host_pkg.sv
design/spi_bit_if.sv
design/spi_cmd_latch.sv
design/spi_seq_fsm.sv
design/spi_shift_io.sv
design/spi_host.sv
testbench/tb_spi_host.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_host -f spi_host.f
	out=$$(./obj_dir/Vtb_spi_host); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
